// File: verilog/noc_pkg.sv
`default_nettype none

package noc_pkg;

  localparam int ID_X_WIDTH      = 2;
  localparam int ID_Y_WIDTH      = 2;
  localparam int TAG_WIDTH       = 4;
  localparam int ADDR_WIDTH      = 16;
  localparam int DATA_WIDTH      = 32;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int LEN_WIDTH       = 3;          // beats = len + 1
  localparam int MEM_WORDS       = 256;
  localparam int FLIT_DATA_WIDTH = 64;

  localparam int BYTE_OFFSET       = $clog2(STRB_WIDTH);
  localparam int MEM_ADDR_WIDTH    = $clog2(MEM_WORDS);
  localparam int WORD_ADDR_WIDTH   = ADDR_WIDTH - BYTE_OFFSET + 1;  // spare bit for overflow
  localparam int LOC_WIDTH         = ID_X_WIDTH + ID_Y_WIDTH;
  localparam int HEADER_PAD_WIDTH  =
    FLIT_DATA_WIDTH - (2 + 2 * LOC_WIDTH + TAG_WIDTH + LEN_WIDTH + 2 + ADDR_WIDTH);
  localparam int PAYLOAD_PAD_WIDTH = FLIT_DATA_WIDTH - DATA_WIDTH - STRB_WIDTH;

  typedef struct packed {
    logic [ID_X_WIDTH-1:0] x;
    logic [ID_Y_WIDTH-1:0] y;
  } location_id_t;

  typedef struct packed {
    location_id_t         location_id;
    logic [TAG_WIDTH-1:0] tag;
  } axi_id_t;

  typedef enum logic [1:0] {
    WRITE_REQUEST  = 2'd0,
    WRITE_RESPONSE = 2'd1
  } packet_type_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_status_e;

  // ************************************************************************
  // flit formats
  // ************************************************************************
  typedef struct packed {
    packet_type_e                packet_type;
    location_id_t                destination_id;
    location_id_t                source_id;
    logic [TAG_WIDTH-1:0]        tag;
    logic [LEN_WIDTH-1:0]        burst_length;
    resp_status_e                status;
    logic [ADDR_WIDTH-1:0]       address;
    logic [HEADER_PAD_WIDTH-1:0] reserved;
  } header_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0]        data;
    logic [STRB_WIDTH-1:0]        byte_enable;
    logic [PAYLOAD_PAD_WIDTH-1:0] reserved;
  } payload_t;

  typedef struct packed {
    logic                       head;
    logic                       tail;
    logic [FLIT_DATA_WIDTH-1:0] body;  // header_t or payload_t
  } flit_t;

  // ************************************************************************
  // write bus
  // ************************************************************************
  typedef struct packed {
    axi_id_t               id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } aw_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } w_t;

  typedef struct packed {
    axi_id_t      id;
    resp_status_e resp;
  } b_t;

endpackage

`default_nettype wire

// File: verilog/packet_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module packet_unpacker (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           flit_in_valid,
  output logic           flit_in_ready,
  input  noc_pkg::flit_t flit_in,
  output logic           aw_valid,
  input  logic           aw_ready,
  output noc_pkg::aw_t   aw,
  output logic           w_valid,
  input  logic           w_ready,
  output noc_pkg::w_t    w
);

  typedef enum logic {
    ST_HEADER,
    ST_PAYLOAD
  } state_e;

  state_e                        state;
  logic [noc_pkg::LEN_WIDTH-1:0] beat_cnt;
  noc_pkg::header_t              header;
  noc_pkg::payload_t             payload;
  logic                          w_free;
  logic                          last_beat;
  logic                          aw_load;
  logic                          w_load;

  assign header    = noc_pkg::header_t'(flit_in.body);
  assign payload   = noc_pkg::payload_t'(flit_in.body);
  assign w_free    = !w_valid || w_ready;
  assign last_beat = (beat_cnt == aw.len) || flit_in.tail || flit_in.head;  // early end

  always_comb begin
    if (state == ST_HEADER) begin
      flit_in_ready = !flit_in.head || !aw_valid || aw_ready;  // stray payload is dropped
    end else begin
      flit_in_ready = w_free && !flit_in.head;  // a new head closes the burst first
    end
  end

  assign aw_load = (state == ST_HEADER) && flit_in_valid && flit_in_ready && flit_in.head;
  assign w_load  = (state == ST_PAYLOAD) && flit_in_valid && w_free;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_HEADER;
      beat_cnt <= '0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) begin
        aw_valid <= 1'b0;
      end
      if (w_valid && w_ready) begin
        w_valid <= 1'b0;
      end
      if (aw_load && !flit_in.tail) begin  // head with tail carries no data
        aw_valid <= 1'b1;
        beat_cnt <= '0;
        state    <= ST_PAYLOAD;
      end
      if (w_load) begin
        w_valid  <= 1'b1;
        beat_cnt <= beat_cnt + 1'b1;
        if (last_beat) begin
          state <= ST_HEADER;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_load) begin
      aw.id.location_id <= header.source_id;
      aw.id.tag         <= header.tag;
      aw.addr           <= header.address;
      aw.len            <= header.burst_length;
    end
    if (w_load) begin
      w.data <= flit_in.head ? '0 : payload.data;
      w.strb <= flit_in.head ? '0 : payload.byte_enable;  // filler beat writes nothing
      w.last <= last_beat;
    end
  end

endmodule

`default_nettype wire

// File: verilog/packet_packer.sv
`timescale 1ns/1ps
`default_nettype none

module packet_packer (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [noc_pkg::ID_X_WIDTH-1:0] id_x,
  input  logic [noc_pkg::ID_Y_WIDTH-1:0] id_y,
  input  logic                           b_valid,
  output logic                           b_ready,
  input  noc_pkg::b_t                    b,
  output logic                           flit_out_valid,
  input  logic                           flit_out_ready,
  output noc_pkg::flit_t                 flit_out
);

  noc_pkg::header_t header;
  logic             b_fire;

  always_comb begin
    header                = '0;
    header.packet_type    = noc_pkg::WRITE_RESPONSE;
    header.destination_id = b.id.location_id;  // back to requester
    header.source_id.x    = id_x;
    header.source_id.y    = id_y;
    header.tag            = b.id.tag;
    header.status         = b.resp;
  end

  assign b_ready = !flit_out_valid;  // one-entry output register
  assign b_fire  = b_valid && b_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flit_out_valid <= 1'b0;
    end else if (b_fire) begin
      flit_out_valid <= 1'b1;
    end else if (flit_out_ready) begin
      flit_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (b_fire) begin
      flit_out.head <= 1'b1;
      flit_out.tail <= 1'b1;  // single-flit packet
      flit_out.body <= header;
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_write_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_adapter (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [noc_pkg::ID_X_WIDTH-1:0] id_x,
  input  logic [noc_pkg::ID_Y_WIDTH-1:0] id_y,
  input  logic                           flit_in_valid,
  output logic                           flit_in_ready,
  input  noc_pkg::flit_t                 flit_in,
  output logic                           flit_out_valid,
  input  logic                           flit_out_ready,
  output noc_pkg::flit_t                 flit_out,
  output logic                           aw_valid,
  input  logic                           aw_ready,
  output noc_pkg::aw_t                   aw,
  output logic                           w_valid,
  input  logic                           w_ready,
  output noc_pkg::w_t                    w,
  input  logic                           b_valid,
  output logic                           b_ready,
  input  noc_pkg::b_t                    b
);

  // ************************************************************************
  // request path, flits to write address and data
  // ************************************************************************
  packet_unpacker u_packet_unpacker (
    .clk           (clk),
    .rst_n         (rst_n),
    .flit_in_valid (flit_in_valid),
    .flit_in_ready (flit_in_ready),
    .flit_in       (flit_in),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .aw            (aw),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .w             (w)
  );

  // ************************************************************************
  // response path, write response to one flit
  // ************************************************************************
  packet_packer u_packet_packer (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_x           (id_x),
    .id_y           (id_y),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .b              (b),
    .flit_out_valid (flit_out_valid),
    .flit_out_ready (flit_out_ready),
    .flit_out       (flit_out)
  );

endmodule

`default_nettype wire

// File: verilog/write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_arbiter (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [1:0]   aw_valid,
  output logic [1:0]   aw_ready,
  input  noc_pkg::aw_t aw [2],
  input  logic [1:0]   w_valid,
  output logic [1:0]   w_ready,
  input  noc_pkg::w_t  w [2],
  output logic [1:0]   b_valid,
  input  logic [1:0]   b_ready,
  output noc_pkg::b_t  b [2],
  output logic         m_aw_valid,
  input  logic         m_aw_ready,
  output noc_pkg::aw_t m_aw,
  output logic         m_w_valid,
  input  logic         m_w_ready,
  output noc_pkg::w_t  m_w,
  input  logic         m_b_valid,
  output logic         m_b_ready,
  input  noc_pkg::b_t  m_b
);

  logic grant_valid;
  logic grant_idx;
  logic prio;     // preferred port for the next grant
  logic aw_done;
  logic w_done;
  logic sel;
  logic cur;

  assign sel = aw_valid[prio] ? prio : !prio;
  assign cur = grant_valid ? grant_idx : sel;  // locked once granted

  assign m_aw_valid = aw_valid[cur] && !aw_done;
  assign m_aw       = aw[cur];
  assign m_w_valid  = grant_valid && !w_done && w_valid[grant_idx];
  assign m_w        = w[grant_idx];
  assign m_b_ready  = grant_valid && b_ready[grant_idx];

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      aw_ready[i] = m_aw_ready && !aw_done && (cur == i[0]);
      w_ready[i]  = m_w_ready && grant_valid && !w_done && (grant_idx == i[0]);
      b_valid[i]  = m_b_valid && grant_valid && (grant_idx == i[0]);
      b[i]        = m_b;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_valid <= 1'b0;
      grant_idx   <= 1'b0;
      prio        <= 1'b0;
      aw_done     <= 1'b0;
      w_done      <= 1'b0;
    end else begin
      if (!grant_valid && m_aw_valid) begin
        grant_valid <= 1'b1;
        grant_idx   <= cur;
        prio        <= !cur;  // move past the winner
      end
      if (m_aw_valid && m_aw_ready) begin
        aw_done <= 1'b1;
      end
      if (m_w_valid && m_w_ready && m_w.last) begin
        w_done <= 1'b1;
      end
      if (m_b_valid && m_b_ready) begin  // release
        grant_valid <= 1'b0;
        aw_done     <= 1'b0;
        w_done      <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/write_memory.sv
`timescale 1ns/1ps
`default_nettype none

module write_memory (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           aw_valid,
  output logic                           aw_ready,
  input  noc_pkg::aw_t                   aw,
  input  logic                           w_valid,
  output logic                           w_ready,
  input  noc_pkg::w_t                    w,
  output logic                           b_valid,
  input  logic                           b_ready,
  output noc_pkg::b_t                    b,
  input  logic [noc_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic [noc_pkg::DATA_WIDTH-1:0] rd_data
);

  logic                                busy;
  logic [noc_pkg::MEM_ADDR_WIDTH-1:0]  word_addr;
  logic [noc_pkg::WORD_ADDR_WIDTH-1:0] end_addr;
  logic                                burst_ok;
  logic [noc_pkg::DATA_WIDTH-1:0]      mem [noc_pkg::MEM_WORDS];

  // last word of the burst, checked once at AW
  assign end_addr = {1'b0, aw.addr[noc_pkg::ADDR_WIDTH-1:noc_pkg::BYTE_OFFSET]}
                  + noc_pkg::WORD_ADDR_WIDTH'(aw.len);
  assign burst_ok = end_addr[noc_pkg::WORD_ADDR_WIDTH-1:noc_pkg::MEM_ADDR_WIDTH] == '0;

  assign aw_ready = !busy;
  assign w_ready  = busy && !b_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) begin
        busy <= 1'b1;
      end
      if (w_valid && w_ready && w.last) begin
        b_valid <= 1'b1;
      end
      if (b_valid && b_ready) begin
        busy    <= 1'b0;
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      word_addr <= aw.addr[noc_pkg::BYTE_OFFSET +: noc_pkg::MEM_ADDR_WIDTH];
      b.id      <= aw.id;
      b.resp    <= burst_ok ? noc_pkg::OKAY : noc_pkg::SLVERR;
    end else if (w_valid && w_ready) begin
      word_addr <= word_addr + 1'b1;
    end
    if (w_valid && w_ready && b.resp == noc_pkg::OKAY) begin  // SLVERR suppresses all beats
      for (int i = 0; i < noc_pkg::STRB_WIDTH; i++) begin
        if (w.strb[i]) begin
          mem[word_addr][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
    rd_data <= mem[rd_addr[noc_pkg::BYTE_OFFSET +: noc_pkg::MEM_ADDR_WIDTH]];
  end

endmodule

`default_nettype wire

// File: verilog/noc_write_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module noc_write_endpoint (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [noc_pkg::ID_X_WIDTH-1:0] id_x,
  input  logic [noc_pkg::ID_Y_WIDTH-1:0] id_y,
  input  logic                           flit_in0_valid,
  output logic                           flit_in0_ready,
  input  noc_pkg::flit_t                 flit_in0,
  output logic                           flit_out0_valid,
  input  logic                           flit_out0_ready,
  output noc_pkg::flit_t                 flit_out0,
  input  logic                           flit_in1_valid,
  output logic                           flit_in1_ready,
  input  noc_pkg::flit_t                 flit_in1,
  output logic                           flit_out1_valid,
  input  logic                           flit_out1_ready,
  output noc_pkg::flit_t                 flit_out1,
  input  logic [noc_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic [noc_pkg::DATA_WIDTH-1:0] rd_data
);

  logic [1:0]   aw_valid;
  logic [1:0]   aw_ready;
  noc_pkg::aw_t aw [2];
  logic [1:0]   w_valid;
  logic [1:0]   w_ready;
  noc_pkg::w_t  w [2];
  logic [1:0]   b_valid;
  logic [1:0]   b_ready;
  noc_pkg::b_t  b [2];

  logic         m_aw_valid;
  logic         m_aw_ready;
  noc_pkg::aw_t m_aw;
  logic         m_w_valid;
  logic         m_w_ready;
  noc_pkg::w_t  m_w;
  logic         m_b_valid;
  logic         m_b_ready;
  noc_pkg::b_t  m_b;

  // ************************************************************************
  // noc ports
  // ************************************************************************
  axi_write_adapter u_adapter0 (
    .clk (clk), .rst_n (rst_n), .id_x (id_x), .id_y (id_y),
    .flit_in_valid  (flit_in0_valid),  .flit_in_ready  (flit_in0_ready),
    .flit_in        (flit_in0),
    .flit_out_valid (flit_out0_valid), .flit_out_ready (flit_out0_ready),
    .flit_out       (flit_out0),
    .aw_valid (aw_valid[0]), .aw_ready (aw_ready[0]), .aw (aw[0]),
    .w_valid  (w_valid[0]),  .w_ready  (w_ready[0]),  .w  (w[0]),
    .b_valid  (b_valid[0]),  .b_ready  (b_ready[0]),  .b  (b[0])
  );

  axi_write_adapter u_adapter1 (
    .clk (clk), .rst_n (rst_n), .id_x (id_x), .id_y (id_y),
    .flit_in_valid  (flit_in1_valid),  .flit_in_ready  (flit_in1_ready),
    .flit_in        (flit_in1),
    .flit_out_valid (flit_out1_valid), .flit_out_ready (flit_out1_ready),
    .flit_out       (flit_out1),
    .aw_valid (aw_valid[1]), .aw_ready (aw_ready[1]), .aw (aw[1]),
    .w_valid  (w_valid[1]),  .w_ready  (w_ready[1]),  .w  (w[1]),
    .b_valid  (b_valid[1]),  .b_ready  (b_ready[1]),  .b  (b[1])
  );

  // ************************************************************************
  // shared write bus and memory
  // ************************************************************************
  write_arbiter u_write_arbiter (
    .clk (clk), .rst_n (rst_n),
    .aw_valid (aw_valid), .aw_ready (aw_ready), .aw (aw),
    .w_valid  (w_valid),  .w_ready  (w_ready),  .w  (w),
    .b_valid  (b_valid),  .b_ready  (b_ready),  .b  (b),
    .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready), .m_aw (m_aw),
    .m_w_valid  (m_w_valid),  .m_w_ready  (m_w_ready),  .m_w  (m_w),
    .m_b_valid  (m_b_valid),  .m_b_ready  (m_b_ready),  .m_b  (m_b)
  );

  write_memory u_write_memory (
    .clk (clk), .rst_n (rst_n),
    .aw_valid (m_aw_valid), .aw_ready (m_aw_ready), .aw (m_aw),
    .w_valid  (m_w_valid),  .w_ready  (m_w_ready),  .w  (m_w),
    .b_valid  (m_b_valid),  .b_ready  (m_b_ready),  .b  (m_b),
    .rd_addr  (rd_addr),    .rd_data  (rd_data)  // local consumer read port
  );

endmodule

`default_nettype wire

// File: verif/tb_noc_write_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module tb_noc_write_endpoint;

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_PACKETS  = 40;  // random packets per port
  localparam int REGION_WORDS = 32;  // words owned by each port
  localparam int TIMEOUT      = 2000;
  localparam logic [noc_pkg::ID_X_WIDTH-1:0] NODE_X = 2'd1;
  localparam logic [noc_pkg::ID_Y_WIDTH-1:0] NODE_Y = 2'd2;

  logic                           clk;
  logic                           rst_n;
  logic [1:0]                     in_valid;
  logic [1:0]                     in_ready;
  noc_pkg::flit_t                 in_flit [2];
  logic [1:0]                     out_valid;
  logic [1:0]                     out_ready = 2'b00;
  noc_pkg::flit_t                 out_flit [2];
  logic [noc_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic [noc_pkg::DATA_WIDTH-1:0] rd_data;

  logic [noc_pkg::DATA_WIDTH-1:0] model [2*REGION_WORDS];  // port 0 low half, port 1 high
  noc_pkg::flit_t                 exp_q0 [$];
  noc_pkg::flit_t                 exp_q1 [$];
  int                             recv_cnt [2] = '{0, 0};

  noc_write_endpoint u_noc_write_endpoint (
    .clk (clk), .rst_n (rst_n), .id_x (NODE_X), .id_y (NODE_Y),
    .flit_in0_valid  (in_valid[0]),  .flit_in0_ready  (in_ready[0]),  .flit_in0  (in_flit[0]),
    .flit_out0_valid (out_valid[0]), .flit_out0_ready (out_ready[0]), .flit_out0 (out_flit[0]),
    .flit_in1_valid  (in_valid[1]),  .flit_in1_ready  (in_ready[1]),  .flit_in1  (in_flit[1]),
    .flit_out1_valid (out_valid[1]), .flit_out1_ready (out_ready[1]), .flit_out1 (out_flit[1]),
    .rd_addr (rd_addr), .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      out_ready <= {($urandom_range(0, 3) != 0), ($urandom_range(0, 3) != 0)};  // ~75% ready
    end
  end

  // **************************************************************************
  // helpers and checks
  // **************************************************************************
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_response(input string name, input noc_pkg::flit_t expected,
                                input noc_pkg::flit_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_word(input string name, input logic [noc_pkg::DATA_WIDTH-1:0] expected,
                            input logic [noc_pkg::DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  function automatic int expected_count(input int p);
    return (p == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  function automatic noc_pkg::flit_t expected_flit(input int p, input int i);
    return (p == 0) ? exp_q0[i] : exp_q1[i];
  endfunction

  function automatic logic [noc_pkg::DATA_WIDTH-1:0] fill_word(input int word);
    return {8'hc5, word[7:0], ~word[7:0], 8'h3a};
  endfunction

  function automatic noc_pkg::flit_t response_flit(input noc_pkg::location_id_t src,
                                                   input logic [noc_pkg::TAG_WIDTH-1:0] tag,
                                                   input noc_pkg::resp_status_e status);
    noc_pkg::header_t h;
    noc_pkg::flit_t   f;
    h                = '0;
    h.packet_type    = noc_pkg::WRITE_RESPONSE;
    h.destination_id = src;  // back to requester
    h.source_id.x    = NODE_X;
    h.source_id.y    = NODE_Y;
    h.tag            = tag;
    h.status         = status;
    f.head           = 1'b1;
    f.tail           = 1'b1;
    f.body           = h;
    return f;
  endfunction

  task automatic put_flit(input int p, input logic valid, input noc_pkg::flit_t f);
    if (p == 0) begin
      in_valid[0] <= valid;
      in_flit[0]  <= f;
    end else begin
      in_valid[1] <= valid;
      in_flit[1]  <= f;
    end
  endtask

  // called on a posedge and returns on the transfer edge
  task automatic send_flit(input int p, input noc_pkg::flit_t f);
    int waited;
    waited = 0;
    put_flit(p, 1'b1, f);
    @(negedge clk);
    while (!in_ready[p]) begin
      if (waited >= TIMEOUT) begin
        report_failure($sformatf("timeout waiting for flit_in ready on port %0d", p));
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    @(posedge clk);
  endtask

  task automatic send_packet(input int p, input int word, input int len, input logic fill);
    noc_pkg::header_t  h;
    noc_pkg::payload_t pl;
    noc_pkg::flit_t    f;
    logic              in_range;
    int                waited;
    @(posedge clk);
    h                  = '0;
    h.packet_type      = noc_pkg::WRITE_REQUEST;
    h.destination_id.x = NODE_X;
    h.destination_id.y = NODE_Y;
    h.source_id        = noc_pkg::LOC_WIDTH'($urandom_range(0, 15));
    h.tag              = noc_pkg::TAG_WIDTH'($urandom_range(0, 15));
    h.burst_length     = noc_pkg::LEN_WIDTH'(len);
    h.address          = noc_pkg::ADDR_WIDTH'(word * 4);
    in_range           = (word + len) < noc_pkg::MEM_WORDS;  // last beat decides
    f = response_flit(h.source_id, h.tag, in_range ? noc_pkg::OKAY : noc_pkg::SLVERR);
    if (p == 0) begin
      exp_q0.push_back(f);
    end else begin
      exp_q1.push_back(f);
    end
    f.head = 1'b1;
    f.tail = 1'b0;
    f.body = h;
    send_flit(p, f);
    for (int i = 0; i <= len; i++) begin
      pl             = '0;
      pl.data        = fill ? fill_word(word + i) : $urandom;
      pl.byte_enable = fill ? '1 : noc_pkg::STRB_WIDTH'($urandom_range(0, 15));
      if (in_range) begin
        for (int b = 0; b < noc_pkg::STRB_WIDTH; b++) begin
          if (pl.byte_enable[b]) begin
            model[word + i][8*b +: 8] = pl.data[8*b +: 8];
          end
        end
      end
      f.head = 1'b0;
      f.tail = (i == len);
      f.body = pl;
      send_flit(p, f);
    end
    put_flit(p, 1'b0, f);
    waited = 0;
    while (recv_cnt[p] < expected_count(p)) begin  // one packet in flight per port
      if (waited >= TIMEOUT) begin
        report_failure($sformatf("timeout waiting for the response flit on port %0d", p));
      end else begin
        waited++;
        @(negedge clk);
      end
    end
  endtask

  task automatic run_port(input int p);
    int base;
    int len;
    int word;
    base = p * REGION_WORDS;
    for (int k = 0; k < REGION_WORDS / 8; k++) begin
      send_packet(p, base + 8 * k, 7, 1'b1);  // known contents first
    end
    for (int n = 0; n < NUM_PACKETS; n++) begin
      len = $urandom_range(0, 7);
      if ($urandom_range(0, 7) == 0) begin
        word = $urandom_range(noc_pkg::MEM_WORDS - len, 300);  // crosses or past the end
      end else begin
        word = base + $urandom_range(0, REGION_WORDS - 1 - len);
      end
      send_packet(p, word, len, 1'b0);
    end
  endtask

  // a transfer seen at negedge completes on the next posedge
  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < 2; p++) begin
        if (out_valid[p] && out_ready[p]) begin
          if (recv_cnt[p] >= expected_count(p)) begin
            report_failure($sformatf("unexpected extra response flit on port %0d", p));
          end else begin
            check_response($sformatf("port%0d response %0d", p, recv_cnt[p]),
                           expected_flit(p, recv_cnt[p]), out_flit[p]);
            recv_cnt[p] = recv_cnt[p] + 1;
          end
        end
      end
    end
  end

  // **************************************************************************
  // main sequence
  // **************************************************************************
  initial begin
    int unsigned seed_val;
    seed_val   = $urandom(32'h020c560a);
    rst_n      <= 1'b0;
    in_valid   <= 2'b00;
    in_flit[0] <= '0;
    in_flit[1] <= '0;
    rd_addr    <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    fork
      run_port(0);
      run_port(1);
    join
    repeat (20) @(posedge clk);  // room for a stray response
    for (int i = 0; i < 2 * REGION_WORDS; i++) begin
      rd_addr <= noc_pkg::ADDR_WIDTH'(i * 4);
      @(posedge clk);
      @(negedge clk);
      check_word($sformatf("read word %0d", i), model[i], rd_data);
      @(posedge clk);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
verilog/noc_pkg.sv
verilog/packet_unpacker.sv
verilog/packet_packer.sv
verilog/axi_write_adapter.sv
verilog/write_arbiter.sv
verilog/write_memory.sv
verilog/noc_write_endpoint.sv
verif/tb_noc_write_endpoint.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_noc_write_endpoint
FILELIST   := project.f
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --top-module $(TOP) -Mdir obj_dir
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
